//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := dma_trace_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- source/dma_bus_decode.sv
// ------------------
// Bus front end of the trace monitor
// De-pipelines AHB manager transfers and decodes APB control accesses
// ------------------
`timescale 1ns/10ps

module dma_bus_decode (
  input  logic          hclk,
  input  logic          hresetn,
  // AHB manager bus
  input  logic          hready,
  input  logic [1:0]    htrans,
  input  logic [31:0]   haddr,
  input  logic          hwrite,
  input  logic [2:0]    hsize,
  input  logic [31:0]   hwdata,
  input  logic [31:0]   hrdata,
  // APB control port
  input  logic          pclken,
  input  logic          psel,
  input  logic          penable,
  input  logic          pwrite,
  input  logic [11:0]   paddr,
  input  logic [31:0]   pwdata,
  input  logic [31:0]   prdata,
  bus_evt_if.src        evt
);

  logic          size_word;
  logic          size_half;
  logic [3:0]    lanes_nxt;
  logic          sel_r;
  logic [31:0]   addr_r;
  logic          write_r;
  logic [3:0]    lanes_r;
  logic [31:0]   data_raw;

  // ------------------
  // AHB address phase
  // ------------------
  assign size_word = (hsize == 3'b010);
  assign size_half = (hsize == 3'b001);

  // Byte lanes of the next transfer
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lanes_nxt[i] = size_word
                   | (size_half & (haddr[1] == i[1]))
                   | (haddr[1:0] == i[1:0]);
    end
  end

  // Data phase pending flag
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      sel_r <= 1'b0;
    end else if (hready) begin
      sel_r <= htrans[1];
    end
  end

  // Address phase attributes held through the data phase
  always_ff @(posedge hclk) begin
    if (hready && htrans[1]) begin
      addr_r  <= haddr;
      write_r <= hwrite;
      lanes_r <= lanes_nxt;
    end
  end

  // ------------------
  // AHB data phase
  // ------------------
  assign data_raw = write_r ? hwdata : hrdata;

  // Unselected lanes read as zero
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      evt.mgr_data[8*i +: 8] = lanes_r[i] ? data_raw[8*i +: 8] : 8'h00;
    end
  end

  assign evt.mgr_done  = sel_r & hready;
  assign evt.mgr_addr  = addr_r;
  assign evt.mgr_write = write_r;

  // ------------------
  // APB control decode
  // ------------------
  assign evt.ctl_hit   = pclken & psel & penable;
  // Word index above 15 is a reserved register
  assign evt.ctl_reg   = (paddr[11:6] != 6'd0) ? dma_trace_pkg::reg_resvd :
                         dma_trace_pkg::pl230_reg_e'({1'b0, paddr[5:2]});
  assign evt.ctl_addr  = paddr;
  assign evt.ctl_write = pwrite;
  assign evt.ctl_data  = pwrite ? pwdata : prdata;

endmodule

//--- source/dma_event_detect.sv
// ------------------
// Event detection of the trace monitor
// Decides which records are due each cycle and fills them in
// ------------------
`timescale 1ns/10ps
`include "dma_trace_defines.svh"

module dma_event_detect (
  input  logic                         hclk,
  input  logic                         hresetn,
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_req,
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_active,
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_done,
  input  logic [`DMA_CHNL_BITS-1:0]    dma_chnl,
  input  dma_trace_pkg::pl230_state_e  dma_ctrl_state,
  bus_evt_if.dst                       evt,
  rec_if.src                           recs
);

  dma_trace_pkg::pl230_state_e  state_r;
  logic [`DMA_NUM_CHNLS-1:0]    req_r;
  logic [`DMA_NUM_CHNLS-1:0]    active_r;
  logic [`DMA_NUM_CHNLS-1:0]    done_r;
  logic [31:0]                  cyc_r;
  logic                         mgr_push;
  logic                         req_push;
  logic                         chn_push;
  logic                         has_addr;

  // States that report on leaving, with no bus transfer of their own
  function automatic logic is_nowait(input dma_trace_pkg::pl230_state_e s);
    return s inside {dma_trace_pkg::st_idle, dma_trace_pkg::st_wait,
                     dma_trace_pkg::st_stall, dma_trace_pkg::st_done,
                     dma_trace_pkg::st_psgp, dma_trace_pkg::st_resvd};
  endfunction

  // Lowest set bit of a one-hot channel vector
  function automatic logic [3:0] low_index(input logic [`DMA_NUM_CHNLS-1:0] vec);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = `DMA_NUM_CHNLS - 1; i >= 0; i--) begin
      if (vec[i]) idx = 4'(i);
    end
    return idx;
  endfunction

  assign mgr_push = evt.mgr_done | ((dma_ctrl_state != state_r) & is_nowait(state_r));
  assign has_addr = !(is_nowait(state_r) ||
                      state_r inside {dma_trace_pkg::st_xc_ini, dma_trace_pkg::st_xc_rdy});
  assign req_push = (dma_req != req_r);
  assign chn_push = ((active_r != dma_active) & (|dma_active))
                  | ((done_r != dma_done) & (|dma_done));

  assign recs.push = {chn_push, req_push, evt.ctl_hit, mgr_push};

  // ------------------
  // Record contents
  // ------------------
  always_comb begin
    recs.rec = '0;
    // Manager record, code is the state being left
    recs.rec[0].kind  = dma_trace_pkg::kind_mgr;
    recs.rec[0].code  = {1'b0, state_r};
    recs.rec[0].chnl  = dma_chnl;
    recs.rec[0].cycle = cyc_r;
    if (has_addr) begin
      recs.rec[0].alt   = evt.mgr_addr[4 + `DMA_CHNL_BITS];
      recs.rec[0].write = evt.mgr_write;
      recs.rec[0].addr  = evt.mgr_addr;
      recs.rec[0].data  = evt.mgr_data;
    end
    // Control register access
    recs.rec[1].kind  = dma_trace_pkg::kind_ctl;
    recs.rec[1].code  = evt.ctl_reg;
    recs.rec[1].write = evt.ctl_write;
    recs.rec[1].addr  = {20'd0, evt.ctl_addr};
    recs.rec[1].data  = evt.ctl_data;
    recs.rec[1].cycle = cyc_r;
    // Request lines
    recs.rec[2].kind  = dma_trace_pkg::kind_req;
    recs.rec[2].data  = 32'(dma_req);
    recs.rec[2].cycle = cyc_r;
    // Active and done channel summary
    recs.rec[3].kind      = dma_trace_pkg::kind_chn;
    recs.rec[3].data[9]   = |dma_done;
    recs.rec[3].data[8]   = |dma_active;
    recs.rec[3].data[7:4] = low_index(dma_active);
    recs.rec[3].data[3:0] = low_index(dma_done);
    recs.rec[3].cycle     = cyc_r;
  end

  // ------------------
  // Tracking state
  // ------------------
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state_r  <= dma_trace_pkg::st_idle;
      req_r    <= '0;
      active_r <= '0;
      done_r   <= '0;
      cyc_r    <= '0;
    end else begin
      cyc_r    <= cyc_r + 32'd1;
      active_r <= dma_active;
      done_r   <= dma_done;
      if (mgr_push) state_r <= dma_ctrl_state;
      if (req_push) req_r <= dma_req;
    end
  end

endmodule

//--- source/dma_trace_defines.svh
// ------------------
// Sizing macros for the DMA trace monitor
// Included by the package and by every block that sizes ports or storage
// ------------------
`ifndef DMA_TRACE_DEFINES_SVH
`define DMA_TRACE_DEFINES_SVH

// Channel set of the watched controller
`define DMA_NUM_CHNLS 4
`define DMA_CHNL_BITS 2

// Record queue entries, a power of two of 4 or more
`define TRACE_DEPTH 8

// Saturating lost record counter
`define TRACE_DROP_BITS 8

`endif

//--- source/dma_trace_if.sv
// ------------------
// Internal links of the trace monitor
// Bus events feed event detection, records feed the trace queue
// ------------------
`timescale 1ns/10ps

interface bus_evt_if;
  logic                       mgr_done;
  logic [31:0]                mgr_addr;
  logic                       mgr_write;
  logic [31:0]                mgr_data;
  logic                       ctl_hit;
  dma_trace_pkg::pl230_reg_e  ctl_reg;
  logic [11:0]                ctl_addr;
  logic                       ctl_write;
  logic [31:0]                ctl_data;

  modport src (output mgr_done, mgr_addr, mgr_write, mgr_data,
               output ctl_hit, ctl_reg, ctl_addr, ctl_write, ctl_data);
  modport dst (input mgr_done, mgr_addr, mgr_write, mgr_data,
               input ctl_hit, ctl_reg, ctl_addr, ctl_write, ctl_data);
endinterface

interface rec_if;
  // One push bit and one record slot per kind, bit 0 is the manager record
  logic [3:0]                        push;
  dma_trace_pkg::trace_rec_t [3:0]   rec;

  modport src (output push, rec);
  modport dst (input push, rec);
endinterface

//--- source/dma_trace_pkg.sv
// ------------------
// Shared types of the DMA trace monitor
// Controller states, APB register indices and the trace record layout
// ------------------
`include "dma_trace_defines.svh"

package dma_trace_pkg;

  // PL230 controller FSM encoding as seen on dma_ctrl_state
  typedef enum logic [3:0] {
    st_idle    = 4'd0,  st_rd_ctrl = 4'd1,  st_rd_sptr = 4'd2,  st_rd_dptr = 4'd3,
    st_rd_sdat = 4'd4,  st_wr_ddat = 4'd5,  st_wait    = 4'd6,  st_wr_ctrl = 4'd7,
    st_stall   = 4'd8,  st_done    = 4'd9,  st_psgp    = 4'd10, st_xc_ini  = 4'd11,
    st_xc_rdy  = 4'd12, st_xr_sdat = 4'd13, st_xw_ddat = 4'd14, st_resvd   = 4'd15
  } pl230_state_e;

  // APB word index of the control registers
  typedef enum logic [4:0] {
    reg_status, reg_cfg, reg_ctrl_base_ptr, reg_alt_ctrl_base_ptr,
    reg_waitonreq_status, reg_sw_request, reg_useburst_set, reg_useburst_clr,
    reg_req_mask_set, reg_req_mask_clr, reg_enable_set, reg_enable_clr,
    reg_pri_alt_set, reg_pri_alt_clr, reg_priority_set, reg_priority_clr,
    reg_resvd
  } pl230_reg_e;

  // Record kind, also the priority order within one cycle
  typedef enum logic [1:0] {
    kind_mgr = 2'd0,
    kind_ctl = 2'd1,
    kind_req = 2'd2,
    kind_chn = 2'd3
  } trace_kind_e;

  typedef struct packed {
    trace_kind_e                kind;
    logic [4:0]                 code;   // state or register index
    logic [`DMA_CHNL_BITS-1:0]  chnl;
    logic                       alt;    // alternate control half
    logic                       write;
    logic [31:0]                addr;
    logic [31:0]                data;
    logic [31:0]                cycle;
  } trace_rec_t;

endpackage

//--- source/dma_trace_queue.sv
// ------------------
// Trace record queue
// Takes up to four records a cycle, emits one a cycle, counts overflow
// ------------------
`timescale 1ns/10ps
`include "dma_trace_defines.svh"

module dma_trace_queue (
  input  logic                          hclk,
  input  logic                          hresetn,
  rec_if.dst                            recs,
  output dma_trace_pkg::trace_rec_t     trace_rec,
  output logic                          trace_valid,
  output logic [`TRACE_DROP_BITS-1:0]   trace_drops
);

  localparam int PTR_BITS = $clog2(`TRACE_DEPTH);

  dma_trace_pkg::trace_rec_t   mem [`TRACE_DEPTH];
  logic [PTR_BITS-1:0]         wr_ptr;
  logic [PTR_BITS-1:0]         rd_ptr;
  logic [PTR_BITS:0]           count;
  logic                        pop;
  logic [PTR_BITS+1:0]         space;
  logic [3:0]                  accept;
  logic [PTR_BITS-1:0]         slot [4];
  logic [2:0]                  n_acc;
  logic [2:0]                  n_drop;
  logic [`TRACE_DROP_BITS:0]   drops_sum;

  assign pop = (count != '0);

  // The entry popped this cycle is free for a push at the same edge
  assign space = (PTR_BITS+2)'(`TRACE_DEPTH) - (PTR_BITS+2)'(count) + (PTR_BITS+2)'(pop);

  // ------------------
  // Push compaction
  // ------------------
  // Lowest kind first, each accepted record takes the next free slot
  always_comb begin
    n_acc  = 3'd0;
    n_drop = 3'd0;
    for (int k = 0; k < 4; k++) begin
      accept[k] = 1'b0;
      slot[k]   = wr_ptr + PTR_BITS'(n_acc);
      if (recs.push[k]) begin
        if ((PTR_BITS+2)'(n_acc) < space) begin
          accept[k] = 1'b1;
          n_acc     = n_acc + 3'd1;
        end else begin
          n_drop = n_drop + 3'd1;
        end
      end
    end
  end

  assign drops_sum = {1'b0, trace_drops} + (`TRACE_DROP_BITS+1)'(n_drop);

  // Storage and output record
  always_ff @(posedge hclk) begin
    for (int k = 0; k < 4; k++) begin
      if (accept[k]) mem[slot[k]] <= recs.rec[k];
    end
    if (pop) trace_rec <= mem[rd_ptr];
  end

  // ------------------
  // Pointers and counters
  // ------------------
  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      trace_valid <= 1'b0;
      trace_drops <= '0;
    end else begin
      wr_ptr      <= wr_ptr + PTR_BITS'(n_acc);
      rd_ptr      <= rd_ptr + PTR_BITS'(pop);
      count       <= count - (PTR_BITS+1)'(pop) + (PTR_BITS+1)'(n_acc);
      trace_valid <= pop;
      // Saturate at all ones
      trace_drops <= drops_sum[`TRACE_DROP_BITS] ? '1 : drops_sum[`TRACE_DROP_BITS-1:0];
    end
  end

endmodule

//--- source/dma_trace_top.sv
// ------------------
// DMA trace monitor top level
// Watches the controller buses and emits one trace record per clock at most
// ------------------
`timescale 1ns/10ps
`include "dma_trace_defines.svh"

module dma_trace_top (
  input  logic                         hclk,
  input  logic                         hresetn,
  // AHB manager bus
  input  logic                         hready,
  input  logic [1:0]                   htrans,
  input  logic [31:0]                  haddr,
  input  logic                         hwrite,
  input  logic [2:0]                   hsize,
  input  logic [31:0]                  hwdata,
  input  logic [31:0]                  hrdata,
  // APB control port
  input  logic                         pclken,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [11:0]                  paddr,
  input  logic [31:0]                  pwdata,
  input  logic [31:0]                  prdata,
  // Controller status
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_req,
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_active,
  input  logic [`DMA_NUM_CHNLS-1:0]    dma_done,
  input  logic [`DMA_CHNL_BITS-1:0]    dma_chnl,
  input  logic [3:0]                   dma_ctrl_state,
  // Trace record stream
  output logic                         trace_valid,
  output logic [1:0]                   trace_kind,
  output logic [4:0]                   trace_code,
  output logic [`DMA_CHNL_BITS-1:0]    trace_chnl,
  output logic                         trace_alt,
  output logic                         trace_write,
  output logic [31:0]                  trace_addr,
  output logic [31:0]                  trace_data,
  output logic [31:0]                  trace_cycle,
  output logic [`TRACE_DROP_BITS-1:0]  trace_drops
);

  bus_evt_if                  u_evt ();
  rec_if                      u_rec ();
  dma_trace_pkg::trace_rec_t  trace_rec;

  dma_bus_decode u_decode (
    .hclk, .hresetn, .hready, .htrans, .haddr, .hwrite, .hsize, .hwdata, .hrdata,
    .pclken, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .evt (u_evt.src)
  );

  dma_event_detect u_detect (
    .hclk, .hresetn, .dma_req, .dma_active, .dma_done, .dma_chnl,
    .dma_ctrl_state (dma_trace_pkg::pl230_state_e'(dma_ctrl_state)),
    .evt            (u_evt.dst),
    .recs           (u_rec.src)
  );

  dma_trace_queue u_queue (
    .hclk, .hresetn,
    .recs        (u_rec.dst),
    .trace_rec   (trace_rec),
    .trace_valid (trace_valid),
    .trace_drops (trace_drops)
  );

  // Record fields on plain ports
  assign trace_kind  = trace_rec.kind;
  assign trace_code  = trace_rec.code;
  assign trace_chnl  = trace_rec.chnl;
  assign trace_alt   = trace_rec.alt;
  assign trace_write = trace_rec.write;
  assign trace_addr  = trace_rec.addr;
  assign trace_data  = trace_rec.data;
  assign trace_cycle = trace_rec.cycle;

endmodule

//--- src.f
+incdir+source
source/dma_trace_pkg.sv
source/dma_trace_if.sv
source/dma_bus_decode.sv
source/dma_event_detect.sv
source/dma_trace_queue.sv
source/dma_trace_top.sv
verif/dma_trace_assert.sv
verif/dma_trace_tb.sv

//--- verif/dma_trace_assert.sv
// ------------------
// Protocol checks on the trace monitor outputs
// Bound into the top level to watch the record stream
// ------------------
`timescale 1ns/10ps
`include "dma_trace_defines.svh"

module dma_trace_assert (
  input  logic                         hclk,
  input  logic                         hresetn,
  input  logic                         trace_valid,
  input  logic [1:0]                   trace_kind,
  input  logic [`TRACE_DROP_BITS-1:0]  trace_drops
);

  // No records while in reset
  valid_in_reset: assert property (@(posedge hclk) !hresetn |-> !trace_valid)
    else $error("trace_valid high during reset");

  kind_known: assert property (@(posedge hclk) disable iff (!hresetn)
    trace_valid |-> !$isunknown(trace_kind))
    else $error("trace_kind unknown on a valid record");

  // Saturating counter only moves up
  drops_monotonic: assert property (@(posedge hclk) disable iff (!hresetn)
    trace_drops >= $past(trace_drops))
    else $error("trace_drops decreased");

endmodule

bind dma_trace_top dma_trace_assert u_assert (.*);

//--- verif/dma_trace_stim.txt
# D/C rdy trn haddr wr sz hwdata hrdata pclk psel pen pwr paddr pwdata prdata req act done chnl st
# E kind code chnl alt write addr data, records of the drive line above in kind order
D 1 0 00000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 4
E 0 00 0 0 0 00000000 00000000
E 3 00 0 0 0 00000000 00000100
D 1 2 10000040 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 4
C 1 0 00000000 0 2 00000000 a1b2c3d4 1 0 0 0 000 00000000 00000000 0 1 0 0 4
E 0 04 0 1 0 10000040 a1b2c3d4
D 1 2 20000012 1 1 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 4
C 1 0 00000000 0 2 11223344 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 4
E 0 04 0 0 1 20000012 11220000
D 1 2 10000043 0 0 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 5
C 1 0 00000000 0 2 00000000 a1b2c3d4 1 0 0 0 000 00000000 00000000 0 1 0 0 5
E 0 04 0 1 0 10000043 a1000000
D 1 2 20000001 1 0 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 5
C 1 0 00000000 0 2 55667788 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 6
E 0 05 0 0 1 20000001 00007700
D 1 0 00000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 7
E 0 06 0 0 0 00000000 00000000
D 1 0 00000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 9
D 1 2 10000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 9
C 1 0 00000000 0 2 00000000 0badf00d 1 0 0 0 000 00000000 00000000 0 1 0 0 9
E 0 07 0 0 0 10000000 0badf00d
D 1 0 00000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 1 0 0 0
E 0 09 0 0 0 00000000 00000000
D 1 0 00000000 0 2 00000000 00000000 1 1 1 1 008 cafe0000 00000000 2 0 1 0 1
E 0 00 0 0 0 00000000 00000000
E 1 02 0 0 1 00000008 cafe0000
E 2 00 0 0 0 00000000 00000002
E 3 00 0 0 0 00000000 00000200
D 1 0 00000000 0 2 00000000 00000000 1 1 1 0 000 00000000 00000003 2 0 1 0 1
E 1 00 0 0 0 00000000 00000003
D 1 0 00000000 0 2 00000000 00000000 1 1 1 0 03c 00000000 0000000f 2 0 1 0 1
E 1 0f 0 0 0 0000003c 0000000f
D 1 0 00000000 0 2 00000000 00000000 1 1 1 1 050 12345678 00000000 2 0 1 0 1
E 1 10 0 0 1 00000050 12345678
D 1 0 00000000 0 2 00000000 00000000 1 0 0 0 000 00000000 00000000 0 4 1 2 1
E 2 00 0 0 0 00000000 00000000
E 3 00 0 0 0 00000000 00000320
D 1 2 10000050 0 2 00000000 00000000 1 1 1 0 004 00000000 000000b0 1 1 1 2 1
E 1 01 0 0 0 00000004 000000b0
E 2 00 0 0 0 00000000 00000001
E 3 00 0 0 0 00000000 00000300
C 1 2 10000004 0 2 00000000 1111aaaa 1 1 1 0 004 00000000 000000b1 2 2 1 2 1
E 0 01 2 1 0 10000050 1111aaaa
E 1 01 0 0 0 00000004 000000b1
E 2 00 0 0 0 00000000 00000002
E 3 00 0 0 0 00000000 00000310
C 1 0 00000000 0 2 00000000 2222bbbb 1 1 1 0 004 00000000 000000b2 4 8 1 2 1
E 0 01 2 0 0 10000004 2222bbbb
E 1 01 0 0 0 00000004 000000b2
E 2 00 0 0 0 00000000 00000004
E 3 00 0 0 0 00000000 00000330

//--- verif/dma_trace_tb.sv
// ------------------
// Testbench of the DMA trace monitor
// Replays the stim file and checks the record stream and the drop count
// ------------------
`timescale 1ns/10ps
`include "dma_trace_defines.svh"

module dma_trace_tb;

  localparam int NF = 19;

  logic                         hclk, hresetn, hready, hwrite;
  logic [1:0]                   htrans;
  logic [31:0]                  haddr, hwdata, hrdata, pwdata, prdata;
  logic [2:0]                   hsize;
  logic                         pclken, psel, penable, pwrite;
  logic [11:0]                  paddr;
  logic [`DMA_NUM_CHNLS-1:0]    dma_req, dma_active, dma_done;
  logic [`DMA_CHNL_BITS-1:0]    dma_chnl;
  logic [3:0]                   dma_ctrl_state;
  logic                         trace_valid, trace_alt, trace_write;
  logic [1:0]                   trace_kind;
  logic [4:0]                   trace_code;
  logic [`DMA_CHNL_BITS-1:0]    trace_chnl;
  logic [31:0]                  trace_addr, trace_data, trace_cycle;
  logic [`TRACE_DROP_BITS-1:0]  trace_drops;

  dma_trace_pkg::trace_rec_t  ref_q[$];
  dma_trace_pkg::trace_rec_t  file_exp_q[$];
  dma_trace_pkg::trace_rec_t  exp_r;
  logic [31:0]                drv_q[$];
  bit                         gap_q[$];
  int                         nexp_q[$];
  int                         n_lines = 0;
  bit                         loaded = 0;
  int                         clk_count;
  int                         mismatches = 0;
  int                         other_errs = 0;
  int                         model_count = 0;
  int                         model_drops = 0;

  dma_trace_top u_dma_trace_top (.*);

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;
  end

  // Clocks since reset release
  always @(posedge hclk or negedge hresetn) begin
    if (!hresetn) clk_count <= 0;
    else clk_count <= clk_count + 1;
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_stim();
    int fd;
    int n;
    string line;
    string tag;
    logic [31:0] v [NF];
    logic [31:0] kind, code, chnl, alt, wr, addr, data;
    dma_trace_pkg::trace_rec_t r;
    fd = $fopen("verif/dma_trace_stim.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open the stimulus file");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n_lines++;
      if (line.getc(0) == "E") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h", tag, kind, code, chnl, alt, wr, addr, data);
        r = '0;
        r.kind  = dma_trace_pkg::trace_kind_e'(kind[1:0]);
        r.code  = code[4:0];
        r.chnl  = chnl[`DMA_CHNL_BITS-1:0];
        r.alt   = alt[0];
        r.write = wr[0];
        r.addr  = addr;
        r.data  = data;
        file_exp_q.push_back(r);
        if (nexp_q.size() > 0) nexp_q[nexp_q.size()-1]++;
      end else begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
        // D lines may take idle gaps before them
        // C lines continue a transfer
        gap_q.push_back(line.getc(0) == "D");
        nexp_q.push_back(0);
        for (int k = 0; k < NF; k++) drv_q.push_back(v[k]);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_line(input int idx);
    int b;
    b = idx * NF;
    hready         = drv_q[b][0];
    htrans         = drv_q[b+1][1:0];
    haddr          = drv_q[b+2];
    hwrite         = drv_q[b+3][0];
    hsize          = drv_q[b+4][2:0];
    hwdata         = drv_q[b+5];
    hrdata         = drv_q[b+6];
    pclken         = drv_q[b+7][0];
    psel           = drv_q[b+8][0];
    penable        = drv_q[b+9][0];
    pwrite         = drv_q[b+10][0];
    paddr          = drv_q[b+11][11:0];
    pwdata         = drv_q[b+12];
    prdata         = drv_q[b+13];
    dma_req        = drv_q[b+14][`DMA_NUM_CHNLS-1:0];
    dma_active     = drv_q[b+15][`DMA_NUM_CHNLS-1:0];
    dma_done       = drv_q[b+16][`DMA_NUM_CHNLS-1:0];
    dma_chnl       = drv_q[b+17][`DMA_CHNL_BITS-1:0];
    dma_ctrl_state = drv_q[b+18][3:0];
  endtask

  // Bus quiet with controller status held
  task automatic idle_bus();
    hready  = 1'b1;
    htrans  = 2'b00;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One clock with n_push records due
  // Queue occupancy follows one pop a cycle
  task automatic step(input int n_push);
    int pop;
    int space;
    int acc;
    dma_trace_pkg::trace_rec_t r;
    pop   = (model_count > 0) ? 1 : 0;
    space = `TRACE_DEPTH - model_count + pop;
    acc   = 0;
    for (int k = 0; k < n_push; k++) begin
      r = file_exp_q.pop_front();
      r.cycle = 32'(clk_count);
      if (acc < space) begin
        ref_q.push_back(r);
        acc++;
      end else if (model_drops < (1 << `TRACE_DROP_BITS) - 1) begin
        model_drops++;
      end
    end
    model_count = model_count - pop + acc;
    @(negedge hclk);
  endtask

  // Outputs are stable at the falling edge
  always @(negedge hclk) begin
    if (hresetn && trace_valid) begin
      if (ref_q.size() == 0) begin
        other_errs++;
        $display("Error at %0t: record of kind %0d arrived with none expected", $time, trace_kind);
      end else begin
        exp_r = ref_q.pop_front();
        check("kind", 32'(trace_kind), 32'(exp_r.kind));
        check("code", 32'(trace_code), 32'(exp_r.code));
        check("chnl", 32'(trace_chnl), 32'(exp_r.chnl));
        check("alt", 32'(trace_alt), 32'(exp_r.alt));
        check("write", 32'(trace_write), 32'(exp_r.write));
        check("addr", trace_addr, exp_r.addr);
        check("data", trace_data, exp_r.data);
        check("cycle", trace_cycle, exp_r.cycle);
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (n_lines * 20) @(posedge hclk);
    $display("Error: watchdog expired before the run finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int gaps;
    hresetn        = 1'b0;
    hready         = 1'b1;
    htrans         = 2'b00;
    haddr          = '0;
    hwrite         = 1'b0;
    hsize          = 3'd2;
    hwdata         = '0;
    hrdata         = '0;
    pclken         = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    prdata         = '0;
    dma_req        = '0;
    dma_active     = '0;
    dma_done       = '0;
    dma_chnl       = '0;
    dma_ctrl_state = '0;
    void'($urandom(32'hbce0d0ea));
    load_stim();
    loaded = 1;
    repeat (8) @(posedge hclk);
    @(negedge hclk);
    hresetn = 1'b1;
    for (int i = 0; i < gap_q.size(); i++) begin
      if (gap_q[i]) begin
        gaps = $urandom_range(0, 3);
        repeat (gaps) begin
          idle_bus();
          step(0);
        end
      end
      apply_line(i);
      step(nexp_q[i]);
    end
    // Drain the queue
    idle_bus();
    while (ref_q.size() > 0) step(0);
    repeat (4) step(0);
    check("trace_drops", 32'(trace_drops), 32'(model_drops));
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
